// ==== rtl/fp16_pkg.sv ====
// ----------------------------------------
// Shared definitions for the fp16 add/sub pipeline
// Format widths, bias, special encodings, latency
// ----------------------------------------

package fp16_pkg;

    // ----------------------------------------
    // IEEE 754 binary16 field layout
    // ----------------------------------------

    // Full word width
    localparam int FP_W = 16;

    // Biased exponent field
    localparam int EXP_W = 5;

    // Stored fraction field, hidden bit not included
    localparam int MAN_W = 10;

    // Exponent bias of the format
    localparam int EXP_BIAS = 15;

    // All-ones exponent marks infinity and NaN
    localparam logic [EXP_W-1:0] EXP_MAX = {EXP_W{1'b1}};

    // ----------------------------------------
    // Special encodings
    // ----------------------------------------

    // Canonical quiet NaN, sign clear and top fraction bit set
    localparam logic [FP_W-1:0] QNAN = 16'h7E00;

    // ----------------------------------------
    // Internal datapath widths
    // ----------------------------------------

    // Guard, round and sticky positions below the fraction
    localparam int GRD_W = 3;

    // Aligned significand
    // hidden bit, fraction and the guard positions
    localparam int SIG_W = 1 + MAN_W + GRD_W;

    // ----------------------------------------
    // Pipeline timing
    // ----------------------------------------

    // Edges from operand sampling to result, sampling edge included
    localparam int PIPE_LAT = 3;

endpackage

// ==== rtl/fp16_decode.sv ====
// ----------------------------------------
// Stage 1 of the fp16 add/sub pipeline
// Unpack, classify specials, order and align
// ----------------------------------------

module fp16_decode
    import fp16_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  logic             op_sub,
    input  logic [FP_W-1:0]  a,
    input  logic [FP_W-1:0]  b,
    output logic             d_valid,
    output logic             d_sign,
    output logic             d_eff_sub,
    output logic [EXP_W-1:0] d_exp,
    output logic [SIG_W-1:0] d_sig_big,
    output logic [SIG_W-1:0] d_sig_small,
    output logic             d_special,
    output logic [FP_W-1:0]  d_special_res,
    output logic             d_invalid
);

    // ----------------------------------------
    // Unpack
    // ----------------------------------------

    logic             sign_a;
    logic             sign_b;
    logic [EXP_W-1:0] exp_a;
    logic [EXP_W-1:0] exp_b;
    logic [MAN_W-1:0] man_a;
    logic [MAN_W-1:0] man_b;

    assign sign_a = a[FP_W-1];
    // Subtraction is addition with b negated
    assign sign_b = b[FP_W-1] ^ op_sub;
    assign exp_a  = a[MAN_W +: EXP_W];
    assign exp_b  = b[MAN_W +: EXP_W];
    assign man_a  = a[MAN_W-1:0];
    assign man_b  = b[MAN_W-1:0];

    // Special classes
    logic nan_a;
    logic nan_b;
    logic inf_a;
    logic inf_b;

    assign nan_a = (exp_a == EXP_MAX) && (man_a != '0);
    assign nan_b = (exp_b == EXP_MAX) && (man_b != '0);
    assign inf_a = (exp_a == EXP_MAX) && (man_a == '0);
    assign inf_b = (exp_b == EXP_MAX) && (man_b == '0);

    // Denormals sit at exponent 1 with a clear hidden bit
    logic [EXP_W-1:0] eexp_a;
    logic [EXP_W-1:0] eexp_b;
    logic [SIG_W-1:0] sig_a;
    logic [SIG_W-1:0] sig_b;

    assign eexp_a = (exp_a == '0) ? EXP_W'(1) : exp_a;
    assign eexp_b = (exp_b == '0) ? EXP_W'(1) : exp_b;
    assign sig_a  = {exp_a != '0, man_a, {GRD_W{1'b0}}};
    assign sig_b  = {exp_b != '0, man_b, {GRD_W{1'b0}}};

    // ----------------------------------------
    // Order by magnitude and align
    // ----------------------------------------

    // Encoding is monotonic in magnitude once the sign is removed
    logic a_big;
    assign a_big = a[FP_W-2:0] >= b[FP_W-2:0];

    logic             sign_big;
    logic [EXP_W-1:0] exp_big;
    logic [EXP_W-1:0] exp_diff;
    logic [SIG_W-1:0] sig_big;
    logic [SIG_W-1:0] sig_small;

    assign sign_big  = a_big ? sign_a : sign_b;
    assign exp_big   = a_big ? eexp_a : eexp_b;
    assign exp_diff  = a_big ? (eexp_a - eexp_b) : (eexp_b - eexp_a);
    assign sig_big   = a_big ? sig_a : sig_b;
    assign sig_small = a_big ? sig_b : sig_a;

    // Right shift with every lost bit folded into the lsb
    logic [SIG_W-1:0] lost_mask;
    logic [SIG_W-1:0] shifted;
    logic             sticky;
    logic [SIG_W-1:0] sig_aligned;

    // Shift counts past the width give an all-ones mask
    assign lost_mask   = ~({SIG_W{1'b1}} << exp_diff);
    assign shifted     = sig_small >> exp_diff;
    assign sticky      = |(sig_small & lost_mask);
    assign sig_aligned = {shifted[SIG_W-1:1], shifted[0] | sticky};

    // ----------------------------------------
    // Special cases
    // ----------------------------------------

    logic            special;
    logic [FP_W-1:0] special_res;
    logic            invalid_c;

    always_comb begin
        special     = 1'b0;
        special_res = QNAN;
        invalid_c   = 1'b0;
        if (nan_a || nan_b) begin
            // Any NaN in gives the canonical NaN, no flag
            special = 1'b1;
        end else if (inf_a && inf_b) begin
            special = 1'b1;
            if (sign_a != sign_b) begin
                // Inf minus inf under the effective operation
                invalid_c = 1'b1;
            end else begin
                special_res = {sign_a, EXP_MAX, {MAN_W{1'b0}}};
            end
        end else if (inf_a) begin
            special     = 1'b1;
            special_res = {sign_a, EXP_MAX, {MAN_W{1'b0}}};
        end else if (inf_b) begin
            // Effective sign, so a minus inf gives -inf
            special     = 1'b1;
            special_res = {sign_b, EXP_MAX, {MAN_W{1'b0}}};
        end
    end

    // ----------------------------------------
    // Stage 1 registers
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            d_valid <= 1'b0;
        end else begin
            d_valid <= in_valid;
        end
    end

    // Payload only moves with a valid operation
    always_ff @(posedge clk) begin
        if (in_valid) begin
            d_sign        <= sign_big;
            d_eff_sub     <= sign_a ^ sign_b;
            d_exp         <= exp_big;
            d_sig_big     <= sig_big;
            d_sig_small   <= sig_aligned;
            d_special     <= special;
            d_special_res <= special_res;
            d_invalid     <= invalid_c;
        end
    end

endmodule

// ==== rtl/fp16_execute.sv ====
// ----------------------------------------
// Stage 2 of the fp16 add/sub pipeline
// Magnitude add or subtract of aligned significands
// ----------------------------------------

module fp16_execute
    import fp16_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             d_valid,
    input  logic             d_sign,
    input  logic             d_eff_sub,
    input  logic [EXP_W-1:0] d_exp,
    input  logic [SIG_W-1:0] d_sig_big,
    input  logic [SIG_W-1:0] d_sig_small,
    input  logic             d_special,
    input  logic [FP_W-1:0]  d_special_res,
    input  logic             d_invalid,
    output logic             e_valid,
    output logic             e_sign,
    output logic [EXP_W-1:0] e_exp,
    output logic [SIG_W:0]   e_sum,
    output logic             e_special,
    output logic [FP_W-1:0]  e_special_res,
    output logic             e_invalid
);

    // ----------------------------------------
    // Adder
    // ----------------------------------------

    // One extra bit on top catches the carry of an addition
    logic [SIG_W:0] big_ext;
    logic [SIG_W:0] small_ext;
    logic [SIG_W:0] sum_c;

    assign big_ext   = {1'b0, d_sig_big};
    assign small_ext = {1'b0, d_sig_small};

    // Decode put the larger magnitude first
    // so the difference never wraps below zero
    always_comb begin
        if (d_eff_sub) begin
            sum_c = big_ext - small_ext;
        end else begin
            sum_c = big_ext + small_ext;
        end
    end

    // ----------------------------------------
    // Stage 2 registers
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            e_valid <= 1'b0;
        end else begin
            e_valid <= d_valid;
        end
    end

    // Sign, exponent and special fields ride along unchanged
    always_ff @(posedge clk) begin
        if (d_valid) begin
            e_sign        <= d_sign;
            e_exp         <= d_exp;
            e_sum         <= sum_c;
            e_special     <= d_special;
            e_special_res <= d_special_res;
            e_invalid     <= d_invalid;
        end
    end

endmodule

// ==== rtl/fp16_result.sv ====
// ----------------------------------------
// Stage 3 of the fp16 add/sub pipeline
// Normalize, truncate, pack, flags, output registers
// ----------------------------------------

module fp16_result
    import fp16_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             e_valid,
    input  logic             e_sign,
    input  logic [EXP_W-1:0] e_exp,
    input  logic [SIG_W:0]   e_sum,
    input  logic             e_special,
    input  logic [FP_W-1:0]  e_special_res,
    input  logic             e_invalid,
    output logic             out_valid,
    output logic [FP_W-1:0]  result,
    output logic             invalid,
    output logic             overflow
);

    // Leading zeros of the sum below the carry bit
    // returns SIG_W for an all-zero input
    function automatic logic [EXP_W-1:0] lead_zeros(input logic [SIG_W-1:0] v);
        logic [EXP_W-1:0] n;
        logic             found;
        n     = EXP_W'(SIG_W);
        found = 1'b0;
        for (int i = SIG_W - 1; i >= 0; i--) begin
            if (v[i] && !found) begin
                n     = EXP_W'(SIG_W - 1 - i);
                found = 1'b1;
            end
        end
        return n;
    endfunction

    // ----------------------------------------
    // Normalize
    // ----------------------------------------

    logic [EXP_W-1:0] lz;
    logic [EXP_W-1:0] lim;
    logic [EXP_W-1:0] shamt;
    logic [SIG_W-1:0] norm;
    logic [EXP_W:0]   exp_n;

    // Left shift stops once the exponent reaches 1
    assign lz    = lead_zeros(e_sum[SIG_W-1:0]);
    assign lim   = e_exp - 1'b1;
    assign shamt = (lz > lim) ? lim : lz;

    always_comb begin
        if (e_sum[SIG_W]) begin
            // Carry out, shift right and keep the dropped bit as sticky
            norm  = {e_sum[SIG_W:2], e_sum[1] | e_sum[0]};
            exp_n = {1'b0, e_exp} + 1'b1;
        end else begin
            norm  = e_sum[SIG_W-1:0] << shamt;
            exp_n = {1'b0, e_exp} - shamt;
        end
    end

    // ----------------------------------------
    // Truncate and pack
    // ----------------------------------------

    logic [MAN_W-1:0] frac;
    logic [EXP_W-1:0] exp_fld;

    // Guard positions are simply dropped
    assign frac    = norm[GRD_W +: MAN_W];
    // Clear hidden bit after a limited shift means a denormal
    assign exp_fld = norm[SIG_W-1] ? exp_n[EXP_W-1:0] : '0;

    logic [FP_W-1:0] res_c;
    logic            ovf_c;

    always_comb begin
        ovf_c = 1'b0;
        if (e_special) begin
            res_c = e_special_res;
        end else if (exp_n >= {1'b0, EXP_MAX}) begin
            // Only reachable through the carry path
            res_c = {e_sign, EXP_MAX, {MAN_W{1'b0}}};
            ovf_c = 1'b1;
        end else if ((exp_fld == '0) && (frac == '0)) begin
            // Exact cancellation and zero operands give +0
            res_c = '0;
        end else begin
            res_c = {e_sign, exp_fld, frac};
        end
    end

    // ----------------------------------------
    // Output registers
    // ----------------------------------------

    // Result and flags hold between operations
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            result    <= '0;
            invalid   <= 1'b0;
            overflow  <= 1'b0;
        end else begin
            out_valid <= e_valid;
            if (e_valid) begin
                result   <= res_c;
                invalid  <= e_invalid;
                overflow <= ovf_c;
            end
        end
    end

endmodule

// ==== rtl/fp16_addsub.sv ====
// ----------------------------------------
// Top level of the pipelined fp16 add/sub unit
// Decode, execute and result stages in a chain
// ----------------------------------------

module fp16_addsub
    import fp16_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    input  logic            op_sub,
    input  logic [FP_W-1:0] a,
    input  logic [FP_W-1:0] b,
    output logic            out_valid,
    output logic [FP_W-1:0] result,
    output logic            invalid,
    output logic            overflow
);

    // Decode to execute
    logic             d_valid;
    logic             d_sign;
    logic             d_eff_sub;
    logic [EXP_W-1:0] d_exp;
    logic [SIG_W-1:0] d_sig_big;
    logic [SIG_W-1:0] d_sig_small;
    logic             d_special;
    logic [FP_W-1:0]  d_special_res;
    logic             d_invalid;

    // Execute to result
    logic             e_valid;
    logic             e_sign;
    logic [EXP_W-1:0] e_exp;
    logic [SIG_W:0]   e_sum;
    logic             e_special;
    logic [FP_W-1:0]  e_special_res;
    logic             e_invalid;

    // Stage 1
    fp16_decode u_decode (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .op_sub        (op_sub),
        .a             (a),
        .b             (b),
        .d_valid       (d_valid),
        .d_sign        (d_sign),
        .d_eff_sub     (d_eff_sub),
        .d_exp         (d_exp),
        .d_sig_big     (d_sig_big),
        .d_sig_small   (d_sig_small),
        .d_special     (d_special),
        .d_special_res (d_special_res),
        .d_invalid     (d_invalid)
    );

    // Stage 2
    fp16_execute u_execute (
        .clk           (clk),
        .rst_n         (rst_n),
        .d_valid       (d_valid),
        .d_sign        (d_sign),
        .d_eff_sub     (d_eff_sub),
        .d_exp         (d_exp),
        .d_sig_big     (d_sig_big),
        .d_sig_small   (d_sig_small),
        .d_special     (d_special),
        .d_special_res (d_special_res),
        .d_invalid     (d_invalid),
        .e_valid       (e_valid),
        .e_sign        (e_sign),
        .e_exp         (e_exp),
        .e_sum         (e_sum),
        .e_special     (e_special),
        .e_special_res (e_special_res),
        .e_invalid     (e_invalid)
    );

    // Stage 3 drives the registered outputs
    fp16_result u_result (
        .clk           (clk),
        .rst_n         (rst_n),
        .e_valid       (e_valid),
        .e_sign        (e_sign),
        .e_exp         (e_exp),
        .e_sum         (e_sum),
        .e_special     (e_special),
        .e_special_res (e_special_res),
        .e_invalid     (e_invalid),
        .out_valid     (out_valid),
        .result        (result),
        .invalid       (invalid),
        .overflow      (overflow)
    );

endmodule

// ==== dv/fp16_addsub_checker.sv ====
// ----------------------------------------
// Result checker for the fp16 add/sub unit
// Exact fixed-point reference model, expected queue
// ----------------------------------------

module fp16_addsub_checker
    import fp16_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    input  logic            op_sub,
    input  logic [FP_W-1:0] a,
    input  logic [FP_W-1:0] b,
    input  logic            out_valid,
    input  logic [FP_W-1:0] result,
    input  logic            invalid,
    input  logic            overflow,
    output int              errors,
    output int              checked
);

    // Expected entry is {invalid, overflow, result}
    logic [FP_W+1:0] exp_q[$];
    logic [FP_W+1:0] exp_v;

    // ----------------------------------------
    // Reference model
    // ----------------------------------------

    // Finite value scaled by 2**24, so the smallest denormal is 1
    function automatic longint to_fixed(input logic [FP_W-1:0] x);
        int     e;
        longint mag;
        e = x[MAN_W +: EXP_W];
        if (e == 0) begin
            mag = x[MAN_W-1:0];
        end else begin
            mag = longint'({1'b1, x[MAN_W-1:0]}) << (e - 1);
        end
        return x[FP_W-1] ? -mag : mag;
    endfunction

    // Back to fp16 with the magnitude truncated
    function automatic logic [FP_W+1:0] pack_fixed(input longint v);
        logic             sgn;
        longint           mag;
        int               p;
        int               e;
        logic [MAN_W-1:0] frac;
        if (v == 0) begin
            return '0;
        end
        sgn = v < 0;
        mag = sgn ? -v : v;
        p   = 0;
        for (int i = 0; i < 63; i++) begin
            if (mag[i]) begin
                p = i;
            end
        end
        // Below the hidden-bit position the value is a denormal
        if (p < MAN_W) begin
            return {2'b00, sgn, {EXP_W{1'b0}}, mag[MAN_W-1:0]};
        end
        e = p - MAN_W + 1;
        if (e >= int'(EXP_MAX)) begin
            return {2'b01, sgn, EXP_MAX, {MAN_W{1'b0}}};
        end
        frac = MAN_W'(mag >> (p - MAN_W));
        return {2'b00, sgn, EXP_W'(e), frac};
    endfunction

    function automatic logic [FP_W+1:0] model_op(input logic [FP_W-1:0] x,
                                                 input logic [FP_W-1:0] y,
                                                 input logic            sub);
        logic [FP_W-1:0] ye;
        logic            nan_x;
        logic            nan_y;
        logic            inf_x;
        logic            inf_y;
        // Operand b with its effective sign
        ye    = {y[FP_W-1] ^ sub, y[FP_W-2:0]};
        nan_x = (x[MAN_W +: EXP_W] == EXP_MAX) && (x[MAN_W-1:0] != '0);
        nan_y = (y[MAN_W +: EXP_W] == EXP_MAX) && (y[MAN_W-1:0] != '0);
        inf_x = (x[MAN_W +: EXP_W] == EXP_MAX) && (x[MAN_W-1:0] == '0);
        inf_y = (y[MAN_W +: EXP_W] == EXP_MAX) && (y[MAN_W-1:0] == '0);
        if (nan_x || nan_y) begin
            return {2'b00, QNAN};
        end
        if (inf_x && inf_y) begin
            return (x[FP_W-1] != ye[FP_W-1]) ? {2'b10, QNAN} : {2'b00, x};
        end
        if (inf_x) begin
            return {2'b00, x};
        end
        if (inf_y) begin
            return {2'b00, ye};
        end
        return pack_fixed(to_fixed(x) + to_fixed(ye));
    endfunction

    // ----------------------------------------
    // Queue and compare
    // ----------------------------------------

    task automatic compare_field(input string name, input logic [FP_W-1:0] expv,
                                 input logic [FP_W-1:0] act);
        if (act !== expv) begin
            errors++;
            $display("ERROR at %0t: %s expected %h actual %h", $time, name, expv, act);
        end
    endtask

    initial begin
        errors  = 0;
        checked = 0;
    end

    // Inputs are stable at the rising edge
    always @(posedge clk) begin
        if (rst_n && in_valid) begin
            exp_q.push_back(model_op(a, b, op_sub));
        end
    end

    // Outputs are compared mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if ($isunknown(out_valid)) begin
                errors++;
                $display("out_valid is unknown at time %0t", $time);
            end else if (out_valid) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("out_valid high at time %0t with no operation pending", $time);
                end else begin
                    exp_v = exp_q.pop_front();
                    checked++;
                    compare_field("result", exp_v[FP_W-1:0], result);
                    compare_field("invalid", FP_W'(exp_v[FP_W+1]), FP_W'(invalid));
                    compare_field("overflow", FP_W'(exp_v[FP_W]), FP_W'(overflow));
                end
            end
        end
    end

endmodule

// ==== dv/fp16_addsub_assert.sv ====
// ----------------------------------------
// Protocol assertions for the fp16 add/sub top
// Bound into every fp16_addsub instance
// ----------------------------------------

module fp16_addsub_assert
    import fp16_pkg::*;
(
    input logic            clk,
    input logic            rst_n,
    input logic            in_valid,
    input logic            out_valid,
    input logic [FP_W-1:0] result,
    input logic            invalid
);

    // Failure count, read by the testbench top
    int fail_count = 0;

    // Each accepted operation comes out PIPE_LAT edges later
    a_latency : assert property (
        @(posedge clk) disable iff (!rst_n) in_valid |-> ##PIPE_LAT out_valid
    ) else begin
        $error("out_valid missing %0d cycles after in_valid", PIPE_LAT);
        fail_count++;
    end

    // No result without an operation behind it
    a_origin : assert property (
        @(posedge clk) disable iff (!rst_n) out_valid |-> $past(in_valid, PIPE_LAT)
    ) else begin
        $error("out_valid without in_valid %0d cycles earlier", PIPE_LAT);
        fail_count++;
    end

    a_known : assert property (
        @(posedge clk) disable iff (!rst_n) out_valid |-> !$isunknown(result)
    ) else begin
        $error("result has unknown bits while out_valid is high");
        fail_count++;
    end

    a_invalid_nan : assert property (
        @(posedge clk) disable iff (!rst_n) invalid |-> (result == QNAN)
    ) else begin
        $error("invalid is set but result is not the quiet NaN");
        fail_count++;
    end

    // Synchronous reset clears out_valid on the next edge
    a_reset : assert property (
        @(posedge clk) !rst_n |=> !out_valid
    ) else begin
        $error("out_valid high during reset");
        fail_count++;
    end

endmodule

bind fp16_addsub fp16_addsub_assert u_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .result    (result),
    .invalid   (invalid)
);

// ==== dv/fp16_addsub_tb.sv ====
// ----------------------------------------
// Testbench top for the fp16 add/sub unit
// Clock, reset, random stimulus, watchdog
// ----------------------------------------

module fp16_addsub_tb
    import fp16_pkg::*;
();

    localparam int CLK_PERIOD    = 4;
    localparam int RST_CYCLES    = 16;
    localparam int SEED          = 47317;
    localparam int N_PHASES      = 3;
    localparam int OPS_PER_PHASE = 400;
    localparam int N_OPS         = N_PHASES * OPS_PER_PHASE;
    localparam int MAX_GAP       = 4;
    // Worst case every operation is followed by the longest gap
    localparam int TIMEOUT = (N_OPS * (MAX_GAP + 1) + RST_CYCLES + 3 * PIPE_LAT + 100)
                             * CLK_PERIOD;

    logic            clk;
    logic            rst_n;
    logic            in_valid;
    logic            op_sub;
    logic [FP_W-1:0] a;
    logic [FP_W-1:0] b;
    logic            out_valid;
    logic [FP_W-1:0] result;
    logic            invalid;
    logic            overflow;
    int              errors;
    int              checked;

    fp16_addsub UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .op_sub    (op_sub),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .result    (result),
        .invalid   (invalid),
        .overflow  (overflow)
    );

    fp16_addsub_checker u_checker (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .op_sub    (op_sub),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .result    (result),
        .invalid   (invalid),
        .overflow  (overflow),
        .errors    (errors),
        .checked   (checked)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------

    // Biased toward zeros, denormals, specials, equal and large magnitudes
    function automatic logic [FP_W-1:0] pick_operand(input logic [FP_W-1:0] other);
        logic sgn;
        sgn = 1'($urandom);
        case ($urandom_range(0, 9))
            0: return {sgn, 15'h0};
            1: return {sgn, {EXP_W{1'b0}}, MAN_W'($urandom)};
            2: return {sgn, EXP_MAX, {MAN_W{1'b0}}};
            3: return {sgn, EXP_MAX, MAN_W'($urandom_range(1, 1023))};
            4: return {sgn, EXP_W'($urandom_range(28, 30)), MAN_W'($urandom)};
            5, 6: return {sgn, other[FP_W-2:0]};
            default: return FP_W'($urandom);
        endcase
    endfunction

    task automatic issue(input logic [FP_W-1:0] x, input logic [FP_W-1:0] y,
                         input logic sub);
        @(negedge clk);
        in_valid = 1'b1;
        a        = x;
        b        = y;
        op_sub   = sub;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            in_valid = 1'b0;
        end
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------

    initial begin
        int              seed_ret;
        int              gap;
        int              total;
        logic [FP_W-1:0] x;
        logic [FP_W-1:0] y;
        in_valid = 1'b0;
        op_sub   = 1'b0;
        a        = '0;
        b        = '0;
        rst_n    = 1'b0;
        seed_ret = $urandom(SEED);
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        idle(2);
        // Phase 0 back-to-back, phase 1 always gapped, phase 2 mixed
        for (int ph = 0; ph < N_PHASES; ph++) begin
            for (int i = 0; i < OPS_PER_PHASE; i++) begin
                x = pick_operand(FP_W'($urandom));
                y = pick_operand(x);
                issue(x, y, 1'($urandom));
                if (ph == 0) begin
                    gap = 0;
                end else if (ph == 1) begin
                    gap = $urandom_range(1, MAX_GAP);
                end else begin
                    gap = $urandom_range(0, 1) * $urandom_range(0, MAX_GAP);
                end
                idle(gap);
            end
        end
        idle(1);
        wait (checked == N_OPS);
        // Extra cycles catch any stray out_valid
        idle(3 * PIPE_LAT);
        total = errors + UUT.u_assert.fail_count;
        $display("Errors: %0d result, %0d assertion; %0d of %0d operations checked",
                 errors, UUT.u_assert.fail_count, checked, N_OPS);
        if (total == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT);
        $display("Timeout: only %0d of %0d operations completed", checked, N_OPS);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== tb.f ====
rtl/fp16_pkg.sv
rtl/fp16_decode.sv
rtl/fp16_execute.sv
rtl/fp16_result.sv
rtl/fp16_addsub.sv
dv/fp16_addsub_checker.sv
dv/fp16_addsub_assert.sv
dv/fp16_addsub_tb.sv
